// ==== verilog/rv_pkg.sv ====
package rv_pkg;

    // RV32I base widths
    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;

    typedef logic [xlen-1:0]      word_t;    // Data, address or CSR vector
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // x0 is hardwired to zero, a write to it is never visible
    localparam reg_idx_t zero_reg = reg_idx_t'(0);

    // Fixed instruction size, no compressed extension
    localparam int unsigned inst_bytes = 4;

    // mepc and mtvec travel as plain words
    // Direct mode only, so the mtvec base is the trap target as is

endpackage

// ==== verilog/pipe_pkg.sv ====
package pipe_pkg;

    import rv_pkg::*;

    // Decode stage view seen by the hazard logic
    typedef struct packed {
        logic     valid;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     mret;     // Return from trap
        logic     ecall;    // Trap to mtvec
    } idu_info_t;

    // Register writing state of EXU, MEM or WBU
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     reg_wen;
        logic     mem_ren;  // Load, data not ready before MEM
    } wr_stage_t;

    // Control flow flags of the instruction in EXU
    typedef struct packed {
        logic branch;       // Taken when ex_result[0] is set
        logic jump;         // jal and jalr, target in ex_result
        logic fence_i;
    } exu_ctrl_t;

    // Source picked for each decode operand
    typedef enum logic [2:0] {
        from_regfile  = 3'b000,
        from_exu      = 3'b001,
        from_wbu      = 3'b010,
        from_mem_load = 3'b011,
        from_mem_alu  = 3'b100
    } fwd_sel_t;

    // Request toward fetch, valid/ready with fetch_ready
    typedef struct packed {
        logic  valid;
        word_t pc;
    } redirect_t;

    // Combinational redirect decision
    typedef struct packed {
        logic  take;        // Some stage redirects this cycle
        logic  fence_i;     // Icache must be cleared too
        word_t pc;          // Target, only meaningful with take
    } redirect_cause_t;

endpackage

// ==== verilog/bypass_unit.sv ====
`timescale 1ns/1ps

module bypass_unit
    import rv_pkg::*, pipe_pkg::*;
(
    input  idu_info_t idu,
    input  wr_stage_t exu,
    input  wr_stage_t mem,
    input  wr_stage_t wbu,

    input  word_t     idu_rs1_value,
    input  word_t     idu_rs2_value,
    input  word_t     ex_result,
    input  word_t     mem_ex_result,
    input  word_t     mem_rdata,
    input  word_t     wbu_rd_value,

    output word_t     exu_rs1_in,
    output word_t     exu_rs2_in,
    output logic      load_use
);

    fwd_sel_t rs1_sel;
    fwd_sel_t rs2_sel;

    // Stage holds a pending write to rs
    function automatic logic writes_reg(input wr_stage_t st, input reg_idx_t rs);
        return st.valid && st.reg_wen && (st.rd == rs) && (st.rd != zero_reg);
    endfunction

    // Youngest writer wins
    function automatic fwd_sel_t pick_src(
        input reg_idx_t  rs,
        input wr_stage_t ex_st,
        input wr_stage_t mem_st,
        input wr_stage_t wb_st
    );
        if (writes_reg(ex_st, rs) && !ex_st.mem_ren) begin
            return from_exu;
        end
        if (writes_reg(mem_st, rs)) begin
            return mem_st.mem_ren ? from_mem_load : from_mem_alu;
        end
        if (writes_reg(wb_st, rs)) begin
            return from_wbu;
        end
        return from_regfile;
    endfunction

    function automatic word_t pick_value(
        input fwd_sel_t sel,
        input word_t    rf_value,
        input word_t    exu_value,
        input word_t    mem_alu_value,
        input word_t    mem_load_value,
        input word_t    wbu_value
    );
        word_t value;
        case (sel)
            from_exu:      value = exu_value;
            from_mem_alu:  value = mem_alu_value;
            from_mem_load: value = mem_load_value;
            from_wbu:      value = wbu_value;
            default:       value = rf_value;
        endcase
        return value;
    endfunction

    assign rs1_sel = pick_src(idu.rs1, exu, mem, wbu);
    assign rs2_sel = pick_src(idu.rs2, exu, mem, wbu);

    assign exu_rs1_in = pick_value(rs1_sel, idu_rs1_value, ex_result,
                                   mem_ex_result, mem_rdata, wbu_rd_value);
    assign exu_rs2_in = pick_value(rs2_sel, idu_rs2_value, ex_result,
                                   mem_ex_result, mem_rdata, wbu_rd_value);

    // Load data only exists after MEM, decode has to wait one cycle
    assign load_use = idu.valid && exu.valid && exu.mem_ren && (exu.rd != zero_reg)
                      && ((exu.rd == idu.rs1) || (exu.rd == idu.rs2));

    // A stall request must come from a real decode slot behind a load
    always_comb begin
        assert final (!load_use || (idu.valid && exu.mem_ren))
            else $error("load_use raised without a decode instruction behind a load");
    end

endmodule

// ==== verilog/redirect_unit.sv ====
`timescale 1ns/1ps

module redirect_unit
    import rv_pkg::*, pipe_pkg::*;
(
    input  idu_info_t       idu,
    input  wr_stage_t       exu,
    input  exu_ctrl_t       exu_ctrl,
    input  word_t           exu_pc,
    input  word_t           exu_imm,
    input  word_t           ex_result,
    input  word_t           mepc,
    input  word_t           mtvec,

    output redirect_cause_t cause
);

    logic  branch_taken;
    logic  exu_take;
    logic  idu_take;
    word_t exu_target;
    word_t idu_target;

    assign branch_taken = exu_ctrl.branch && ex_result[0];   // Compare result in bit 0

    // EXU is older, so it overrides a trap sitting in decode
    assign exu_take = exu.valid && (exu_ctrl.jump || branch_taken || exu_ctrl.fence_i);
    assign idu_take = idu.valid && (idu.mret || idu.ecall);

    always_comb begin
        if (exu_ctrl.jump) begin
            exu_target = ex_result;                     // jalr already masked in EXU
        end else if (branch_taken) begin
            exu_target = exu_pc + exu_imm;
        end else begin
            exu_target = exu_pc + word_t'(inst_bytes);  // Refetch after fence.i
        end
    end

    assign idu_target = idu.mret ? mepc : mtvec;

    always_comb begin
        cause.take    = exu_take || idu_take;
        cause.fence_i = exu.valid && exu_ctrl.fence_i;
        cause.pc      = exu_take ? exu_target : idu_target;
    end

    // Icache clear must never go out without a refetch
    always_comb begin
        assert final (!cause.fence_i || cause.take)
            else $error("fence.i marked without a redirect");
    end

endmodule

// ==== verilog/hazard_arbiter.sv ====
`timescale 1ns/1ps

module hazard_arbiter
    import rv_pkg::*, pipe_pkg::*;
(
    input  logic            clock,
    input  logic            reset,

    input  redirect_cause_t cause,
    input  logic            load_use,
    input  logic            fetch_ready,

    output logic            flush,
    output logic            stall,
    output logic            icache_clr,
    output redirect_t       redirect
);

    logic  redirect_valid_q;
    word_t redirect_pc_q;
    logic  icache_clr_q;
    logic  transfer;

    // Decode slot is dropped on any redirect
    assign flush = cause.take;
    // A stalled instruction gets killed anyway, no point holding it
    assign stall = load_use && !cause.take;

    assign transfer = redirect_valid_q && fetch_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            redirect_valid_q <= 1'b0;
            icache_clr_q     <= 1'b0;
        end else begin
            if (cause.take) begin
                redirect_valid_q <= 1'b1;       // New target wins over a pending one
            end else if (transfer) begin
                redirect_valid_q <= 1'b0;
            end
            icache_clr_q <= cause.take && cause.fence_i;   // One cycle pulse
        end
    end

    always_ff @(posedge clock) begin
        if (cause.take) begin
            redirect_pc_q <= cause.pc;
        end
    end

    assign redirect.valid = redirect_valid_q;
    assign redirect.pc    = redirect_pc_q;
    assign icache_clr     = icache_clr_q;

    a_no_stall_on_flush: assert property (
        @(posedge clock) disable iff (reset)
        !(stall && flush)
    ) else $error("stall and flush high together");

    // Fetch sees a stable target until it takes it
    a_pc_held: assert property (
        @(posedge clock) disable iff (reset)
        redirect.valid && !fetch_ready && !cause.take
            |=> redirect.valid && $stable(redirect.pc)
    ) else $error("pending redirect changed without a new event");

    // Cache clear always comes together with the refetch request
    a_clr_with_redirect: assert property (
        @(posedge clock) disable iff (reset)
        icache_clr |-> redirect.valid
    ) else $error("icache_clr without redirect.valid");

endmodule

// ==== verilog/pipe_control.sv ====
`timescale 1ns/1ps

module pipe_control
    import rv_pkg::*, pipe_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    input  idu_info_t idu,
    input  word_t     idu_rs1_value,
    input  word_t     idu_rs2_value,

    input  wr_stage_t exu,
    input  exu_ctrl_t exu_ctrl,
    input  word_t     exu_pc,
    input  word_t     exu_imm,
    input  word_t     ex_result,

    input  wr_stage_t mem,
    input  word_t     mem_ex_result,
    input  word_t     mem_rdata,

    input  wr_stage_t wbu,
    input  word_t     wbu_rd_value,

    input  word_t     mepc,
    input  word_t     mtvec,
    input  logic      fetch_ready,

    output word_t     exu_rs1_in,
    output word_t     exu_rs2_in,
    output logic      stall,
    output logic      flush,
    output redirect_t redirect,
    output logic      icache_clr
);

    logic            load_use;
    redirect_cause_t cause;

    bypass_unit bypass_i (
        .idu           (idu          ),
        .exu           (exu          ),
        .mem           (mem          ),
        .wbu           (wbu          ),
        .idu_rs1_value (idu_rs1_value),
        .idu_rs2_value (idu_rs2_value),
        .ex_result     (ex_result    ),
        .mem_ex_result (mem_ex_result),
        .mem_rdata     (mem_rdata    ),
        .wbu_rd_value  (wbu_rd_value ),
        .exu_rs1_in    (exu_rs1_in   ),
        .exu_rs2_in    (exu_rs2_in   ),
        .load_use      (load_use     )
    );

    redirect_unit redirect_i (
        .idu       (idu      ),
        .exu       (exu      ),
        .exu_ctrl  (exu_ctrl ),
        .exu_pc    (exu_pc   ),
        .exu_imm   (exu_imm  ),
        .ex_result (ex_result),
        .mepc      (mepc     ),
        .mtvec     (mtvec    ),
        .cause     (cause    )
    );

    hazard_arbiter arbiter_i (
        .clock       (clock      ),
        .reset       (reset      ),
        .cause       (cause      ),
        .load_use    (load_use   ),
        .fetch_ready (fetch_ready),
        .flush       (flush      ),
        .stall       (stall      ),
        .icache_clr  (icache_clr ),
        .redirect    (redirect   )
    );

endmodule

// ==== testbench/tb_pipe_model.svh ====
`ifndef TB_PIPE_MODEL_SVH
`define TB_PIPE_MODEL_SVH

// Operand value seen by EXU, youngest writer wins
function automatic word_t forwarded_operand(
    input reg_idx_t  rs,
    input word_t     rf_value,
    input wr_stage_t ex_st,
    input word_t     ex_value,
    input wr_stage_t mem_st,
    input word_t     mem_alu_value,
    input word_t     mem_load_value,
    input wr_stage_t wb_st,
    input word_t     wb_value
);
    word_t value;
    value = rf_value;
    if (rs != 5'd0) begin
        // Walk from oldest to youngest so a later match overrides
        if (wb_st.valid && wb_st.reg_wen && wb_st.rd == rs) begin
            value = wb_value;
        end
        if (mem_st.valid && mem_st.reg_wen && mem_st.rd == rs) begin
            value = mem_st.mem_ren ? mem_load_value : mem_alu_value;
        end
        if (ex_st.valid && ex_st.reg_wen && !ex_st.mem_ren && ex_st.rd == rs) begin
            value = ex_value;
        end
    end
    return value;
endfunction

// Decode depends on a load still in EXU
function automatic logic load_use_hazard(input idu_info_t id, input wr_stage_t ex);
    logic hit;
    hit = (ex.rd == id.rs1) || (ex.rd == id.rs2);
    return id.valid && ex.valid && ex.mem_ren && (ex.rd != 5'd0) && hit;
endfunction

function automatic logic redirect_taken(
    input idu_info_t id,
    input wr_stage_t ex,
    input exu_ctrl_t ctrl,
    input word_t     result
);
    logic from_ex;
    from_ex = ex.valid && (ctrl.jump || ctrl.fence_i || (ctrl.branch && result[0]));
    return from_ex || (id.valid && (id.mret || id.ecall));
endfunction

function automatic word_t redirect_target(
    input idu_info_t id,
    input wr_stage_t ex,
    input exu_ctrl_t ctrl,
    input word_t     result,
    input word_t     pc,
    input word_t     imm,
    input word_t     epc,
    input word_t     tvec
);
    if (ex.valid && ctrl.jump) begin
        return result;
    end
    if (ex.valid && ctrl.branch && result[0]) begin
        return pc + imm;
    end
    if (ex.valid && ctrl.fence_i) begin
        return pc + 32'd4;                      // Next instruction
    end
    return (id.valid && id.mret) ? epc : tvec;
endfunction

`endif

// ==== testbench/tb_pipe_control.sv ====
`timescale 1ns/1ps

module tb_pipe_control
    import rv_pkg::*, pipe_pkg::*;
;

    `include "tb_pipe_model.svh"

    localparam int          clock_period   = 4;
    localparam int          reset_cycles   = 8;
    localparam int          wait_limit     = 20;   // Cycles per wait on redirect.valid
    localparam int unsigned seed           = 61743;
    localparam int          bypass_vectors = 300;

    localparam exu_ctrl_t ctrl_none   = '{branch: 1'b0, jump: 1'b0, fence_i: 1'b0};
    localparam exu_ctrl_t ctrl_jump   = '{branch: 1'b0, jump: 1'b1, fence_i: 1'b0};
    localparam exu_ctrl_t ctrl_branch = '{branch: 1'b1, jump: 1'b0, fence_i: 1'b0};
    localparam exu_ctrl_t ctrl_fence  = '{branch: 1'b0, jump: 1'b0, fence_i: 1'b1};

    logic      clock;
    logic      reset;
    idu_info_t idu;
    word_t     idu_rs1_value;
    word_t     idu_rs2_value;
    wr_stage_t exu;
    exu_ctrl_t exu_ctrl;
    word_t     exu_pc;
    word_t     exu_imm;
    word_t     ex_result;
    wr_stage_t mem;
    word_t     mem_ex_result;
    word_t     mem_rdata;
    wr_stage_t wbu;
    word_t     wbu_rd_value;
    word_t     mepc;
    word_t     mtvec;
    logic      fetch_ready;

    word_t     exu_rs1_in;
    word_t     exu_rs2_in;
    logic      stall;
    logic      flush;
    redirect_t redirect;
    logic      icache_clr;

    word_t     exp_rs1;
    word_t     exp_rs2;
    word_t     exp_target;
    logic      exp_take;
    logic      exp_stall;
    logic      exp_fence;

    int        check_errors;
    int        errors_at_start;
    int        tests_passed;
    int        tests_failed;

    pipe_control dut_i (.*);

    always #(clock_period / 2) clock = ~clock;

    always_comb begin
        exp_rs1    = forwarded_operand(idu.rs1, idu_rs1_value, exu, ex_result, mem,
                                       mem_ex_result, mem_rdata, wbu, wbu_rd_value);
        exp_rs2    = forwarded_operand(idu.rs2, idu_rs2_value, exu, ex_result, mem,
                                       mem_ex_result, mem_rdata, wbu, wbu_rd_value);
        exp_take   = redirect_taken(idu, exu, exu_ctrl, ex_result);
        exp_target = redirect_target(idu, exu, exu_ctrl, ex_result, exu_pc, exu_imm,
                                     mepc, mtvec);
        exp_stall  = load_use_hazard(idu, exu) && !exp_take;
        exp_fence  = exp_take && exu.valid && exu_ctrl.fence_i;
    end

    task automatic report_mismatch(input string msg);
        check_errors++;
        $display("CHECK FAILED at time %0t: %s", $time, msg);
    endtask

    a_reset_quiet: assert property (@(posedge clock)
        $past(reset) |-> !redirect.valid && !icache_clr)
        else report_mismatch("redirect.valid or icache_clr high in or right after reset");

    a_rs1: assert property (@(posedge clock) disable iff (reset) exu_rs1_in == exp_rs1)
        else report_mismatch("rs1 operand differs from the first-match source");
    a_rs2: assert property (@(posedge clock) disable iff (reset) exu_rs2_in == exp_rs2)
        else report_mismatch("rs2 operand differs from the first-match source");

    a_stall: assert property (@(posedge clock) disable iff (reset) stall == exp_stall)
        else report_mismatch("stall differs from the load-use rule");
    a_flush: assert property (@(posedge clock) disable iff (reset) flush == exp_take)
        else report_mismatch("flush differs from the redirect condition");

    // Registered one clock after the event
    a_redirect_load: assert property (@(posedge clock) disable iff (reset)
        exp_take |=> redirect.valid && redirect.pc == $past(exp_target))
        else report_mismatch("redirect not raised with the expected target");
    a_redirect_hold: assert property (@(posedge clock) disable iff (reset)
        redirect.valid && !fetch_ready && !exp_take |=> redirect.valid && $stable(redirect.pc))
        else report_mismatch("pending redirect dropped or changed under back-pressure");
    a_redirect_done: assert property (@(posedge clock) disable iff (reset)
        redirect.valid && fetch_ready && !exp_take |=> !redirect.valid)
        else report_mismatch("redirect still valid after the transfer edge");
    a_no_spurious: assert property (@(posedge clock) disable iff (reset)
        !redirect.valid && !exp_take |=> !redirect.valid)
        else report_mismatch("redirect raised without an event");

    a_icache_pulse: assert property (@(posedge clock) disable iff (reset)
        icache_clr == $past(exp_fence))
        else report_mismatch("icache_clr is not the one-cycle pulse after fence.i");

    function automatic wr_stage_t random_stage();
        wr_stage_t st;
        st.valid   = ($urandom_range(0, 3) != 0);
        st.rd      = reg_idx_t'($urandom_range(0, 3));     // Small range to get matches
        st.reg_wen = ($urandom_range(0, 3) != 0);
        st.mem_ren = 1'($urandom_range(0, 1));
        return st;
    endfunction

    task automatic randomize_words();
        idu_rs1_value = $urandom();
        idu_rs2_value = $urandom();
        exu_pc        = $urandom() & 32'hffff_fffc;
        exu_imm       = $urandom() & 32'h0000_1ffe;
        ex_result     = $urandom();
        mem_ex_result = $urandom();
        mem_rdata     = $urandom();
        wbu_rd_value  = $urandom();
        mepc          = $urandom() & 32'hffff_fffc;
        mtvec         = $urandom() & 32'hffff_fffc;
    endtask

    task automatic clear_control();
        idu      = '0;
        exu      = '0;
        mem      = '0;
        wbu      = '0;
        exu_ctrl = ctrl_none;
    endtask

    // One event cycle, then idle again
    task automatic send_event(input exu_ctrl_t ctrl, input logic cmp_bit,
                              input logic mret, input logic ecall);
        @(negedge clock);
        randomize_words();
        clear_control();
        exu.valid    = (ctrl != ctrl_none);
        exu.rd       = reg_idx_t'($urandom_range(1, 31));
        exu.reg_wen  = ctrl.jump;                   // Link register
        exu_ctrl     = ctrl;
        ex_result[0] = cmp_bit;
        idu.valid    = mret || ecall;
        idu.rs1      = reg_idx_t'($urandom_range(0, 31));
        idu.rs2      = reg_idx_t'($urandom_range(0, 31));
        idu.mret     = mret;
        idu.ecall    = ecall;
        @(negedge clock);
        clear_control();
    endtask

    task automatic wait_redirect(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (redirect.valid !== level && cycles < wait_limit) begin
            @(negedge clock);
            cycles++;
        end
        if (redirect.valid !== level) begin
            check_errors++;
            $display("Timeout: redirect.valid did not go %0d within %0d cycles during %s",
                     level, wait_limit, what);
        end
    endtask

    task automatic finish_test(input string name);
        @(negedge clock);
        clear_control();
        fetch_ready = 1'b1;
        repeat (3) @(negedge clock);                // Let the delayed checks run
        if (check_errors == errors_at_start) begin
            tests_passed++;
            $display("%-14s ok", name);
        end else begin
            tests_failed++;
            $display("%-14s failed with %0d errors", name, check_errors - errors_at_start);
        end
        errors_at_start = check_errors;
    endtask

    initial begin
        clock           = 1'b0;
        reset           = 1'b1;
        fetch_ready     = 1'b1;
        check_errors    = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        void'($urandom(seed));
        clear_control();
        randomize_words();

        repeat (reset_cycles) @(negedge clock);
        reset = 1'b0;
        finish_test("reset");

        for (int i = 0; i < bypass_vectors; i++) begin
            @(negedge clock);
            randomize_words();
            idu       = '0;
            idu.valid = 1'($urandom_range(0, 1));
            idu.rs1   = reg_idx_t'($urandom_range(0, 3));
            idu.rs2   = reg_idx_t'($urandom_range(0, 3));
            exu       = random_stage();
            mem       = random_stage();
            wbu       = random_stage();
            exu_ctrl  = ctrl_none;
            fetch_ready = 1'($urandom_range(0, 1));
        end
        finish_test("bypass");

        @(negedge clock);
        idu = '{valid: 1'b1, rs1: 5'd5, rs2: 5'd6, mret: 1'b0, ecall: 1'b0};
        exu = '{valid: 1'b1, rd: 5'd5, reg_wen: 1'b1, mem_ren: 1'b1};   // rs1 hit
        @(negedge clock);
        exu.rd = 5'd6;                              // rs2 hit
        @(negedge clock);
        exu.rd = 5'd7;                              // No hit
        @(negedge clock);
        exu.rd  = 5'd0;
        idu.rs1 = 5'd0;
        @(negedge clock);
        exu.rd    = 5'd5;
        idu.rs1   = 5'd5;
        idu.ecall = 1'b1;                           // Flush masks the stall
        @(negedge clock);
        idu.ecall = 1'b0;
        idu.valid = 1'b0;
        finish_test("load_use");

        fetch_ready = 1'b1;
        send_event(ctrl_jump, 1'b0, 1'b0, 1'b0);
        wait_redirect(1'b1, "jump");
        wait_redirect(1'b0, "jump transfer");
        send_event(ctrl_branch, 1'b1, 1'b0, 1'b0);
        wait_redirect(1'b1, "taken branch");
        wait_redirect(1'b0, "taken branch transfer");
        send_event(ctrl_branch, 1'b0, 1'b0, 1'b0);  // Not taken, nothing follows
        repeat (2) @(negedge clock);
        send_event(ctrl_none, 1'b0, 1'b1, 1'b0);
        wait_redirect(1'b1, "mret");
        wait_redirect(1'b0, "mret transfer");
        send_event(ctrl_none, 1'b0, 1'b0, 1'b1);
        wait_redirect(1'b1, "ecall");
        wait_redirect(1'b0, "ecall transfer");
        send_event(ctrl_jump, 1'b0, 1'b0, 1'b1);    // EXU beats IDU
        wait_redirect(1'b1, "priority");
        wait_redirect(1'b0, "priority transfer");
        finish_test("redirect");

        @(negedge clock);
        fetch_ready = 1'b0;
        send_event(ctrl_jump, 1'b0, 1'b0, 1'b0);
        repeat ($urandom_range(2, 8)) @(negedge clock);
        send_event(ctrl_branch, 1'b1, 1'b0, 1'b0);  // Replaces the pending target
        repeat ($urandom_range(2, 8)) @(negedge clock);
        fetch_ready = 1'b1;
        wait_redirect(1'b0, "back-pressure transfer");
        finish_test("backpressure");

        send_event(ctrl_fence, 1'b0, 1'b0, 1'b0);
        wait_redirect(1'b1, "fence.i");
        wait_redirect(1'b0, "fence.i transfer");
        @(negedge clock);
        fetch_ready = 1'b0;
        send_event(ctrl_fence, 1'b0, 1'b0, 1'b0);
        repeat (3) @(negedge clock);
        fetch_ready = 1'b1;
        wait_redirect(1'b0, "held fence.i transfer");
        finish_test("fence_i");

        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, check_errors);
        if (tests_failed == 0 && check_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+testbench
verilog/rv_pkg.sv
verilog/pipe_pkg.sv
verilog/bypass_unit.sv
verilog/redirect_unit.sv
verilog/hazard_arbiter.sv
verilog/pipe_control.sv
testbench/tb_pipe_control.sv
